//--- common/modsq_pkg.sv
// Modular squaring engine package with modulus, limb and register constants and shared types
`default_nettype none

package modsq_pkg;

    // Limb layout of the loop value
    localparam int LIMB_W    = 8;
    localparam int NUM_LIMBS = 5;
    localparam int NUM_COLS  = 2 * NUM_LIMBS - 1;
    // Widest column sum is 5 limb products of 16 bits
    localparam int COL_W     = 2 * LIMB_W + 3;
    localparam int VALUE_W   = NUM_LIMBS * LIMB_W;
    localparam int PROD_W    = 2 * VALUE_W;

    // Modulus P = 2^32 - 5, so 2^32 mod P = 5
    localparam int MOD_W = 32;
    localparam logic [MOD_W-1:0] MOD_P = 32'hFFFF_FFFB;
    localparam logic [2:0] FOLD_C = 3'd5;

    localparam int ITER_W = 16;

    // APB register map
    localparam int ADDR_W = 8;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_ITER   = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_X_IN   = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_X_OUT  = 8'h10;

    typedef enum logic [2:0] {IDLE, LOAD, SQUARE, FOLD, NORMALIZE, DONE} loop_state_t;

    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [PROD_W-1:0]  prod_t;

endpackage

`default_nettype wire

//--- rtl/modsq_apb_regs.sv
// APB register block holding operand, iteration count, start, status and result
`default_nettype none

module modsq_apb_regs (
    input  wire  logic                          clk,
    input  wire  logic                          reset,
    input  wire  logic                          psel,
    input  wire  logic                          penable,
    input  wire  logic                          pwrite,
    input  wire  logic [modsq_pkg::ADDR_W-1:0]  paddr,
    input  wire  logic [31:0]                   pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire  logic                          busy,
    input  wire  logic                          result_valid,
    input  wire  logic [modsq_pkg::MOD_W-1:0]   result,
    output logic                                start,
    output logic [modsq_pkg::MOD_W-1:0]         x_in,
    output logic [modsq_pkg::ITER_W-1:0]        iter_count
);
    import modsq_pkg::*;

    logic [ITER_W-1:0] iter_q;
    logic [MOD_W-1:0]  x_in_q;
    logic [MOD_W-1:0]  result_q;
    logic              done_q;
    logic              start_q;
    logic              engine_busy;
    logic              access;
    logic              addr_hit;
    logic              wr_allowed;
    logic              wr_en;
    logic              start_wr;

    // The start pulse cycle already counts as busy
    assign engine_busy = busy | start_q;
    assign access      = psel & penable;

    always_comb begin
        addr_hit   = 1'b1;
        wr_allowed = 1'b0;
        case (paddr)
            ADDR_CTRL, ADDR_ITER, ADDR_X_IN: wr_allowed = !engine_busy;
            ADDR_STATUS, ADDR_X_OUT:         wr_allowed = 1'b0;
            default:                         addr_hit   = 1'b0;
        endcase
    end

    assign pready   = 1'b1;
    assign pslverr  = access & (!addr_hit | (pwrite & !wr_allowed));
    assign wr_en    = access & pwrite & !pslverr;
    assign start_wr = wr_en & (paddr == ADDR_CTRL) & pwdata[0];

    always_comb begin
        case (paddr)
            ADDR_ITER:   prdata = {{(32 - ITER_W){1'b0}}, iter_q};
            ADDR_X_IN:   prdata = x_in_q;
            ADDR_STATUS: prdata = {30'd0, done_q, engine_busy};
            ADDR_X_OUT:  prdata = result_q;
            default:     prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iter_q   <= '0;
            x_in_q   <= '0;
            result_q <= '0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            start_q <= start_wr;
            if (wr_en && paddr == ADDR_ITER) begin
                iter_q <= pwdata[ITER_W-1:0];
            end
            if (wr_en && paddr == ADDR_X_IN) begin
                x_in_q <= pwdata;
            end
            // A new run hides the previous completion
            if (start_wr) begin
                done_q <= 1'b0;
            end else if (result_valid) begin
                done_q <= 1'b1;
            end
            if (result_valid) begin
                result_q <= result;
            end
        end
    end

    assign start      = start_q;
    assign x_in       = x_in_q;
    assign iter_count = iter_q;

    // Rejected writes leave the operands alone and never launch a run
    assert property (@(posedge clk) disable iff (reset)
        pslverr && pwrite |=> $stable(iter_q) && $stable(x_in_q) && !start_q);

endmodule

`default_nettype wire

//--- square/limb_square_array.sv
// Limb squaring array that sums weighted column products into a registered full square
`default_nettype none

module limb_square_array (
    input  wire  logic              clk,
    input  wire  modsq_pkg::value_t loop_value,
    output modsq_pkg::prod_t        product
);
    import modsq_pkg::*;

    logic [LIMB_W-1:0] limb [NUM_LIMBS];
    logic [COL_W-1:0]  col_sum [NUM_COLS];
    prod_t             prod_next;

    always_comb begin
        for (int i = 0; i < NUM_LIMBS; i++) begin
            limb[i] = loop_value[i*LIMB_W +: LIMB_W];
        end
    end

    // Each column k collects every limb pair with i + j == k
    // Off-diagonal pairs appear twice in a square, so they are doubled once here
    always_comb begin
        logic [2*LIMB_W-1:0] pp;
        pp = '0;
        for (int k = 0; k < NUM_COLS; k++) begin
            col_sum[k] = '0;
        end
        for (int i = 0; i < NUM_LIMBS; i++) begin
            for (int j = i; j < NUM_LIMBS; j++) begin
                pp = limb[i] * limb[j];
                if (i == j) begin
                    col_sum[i+j] = col_sum[i+j] + COL_W'(pp);
                end else begin
                    col_sum[i+j] = col_sum[i+j] + COL_W'({pp, 1'b0});
                end
            end
        end
    end

    // Carry resolution by weighting each column sum and adding
    always_comb begin
        prod_next = '0;
        for (int k = 0; k < NUM_COLS; k++) begin
            prod_next = prod_next + (prod_t'(col_sum[k]) << (LIMB_W * k));
        end
    end

    always_ff @(posedge clk) begin
        product <= prod_next;
    end

endmodule

`default_nettype wire

//--- square/fold_reduce.sv
// Two-stage fold of a square modulo P into a registered value below 2P
`default_nettype none

module fold_reduce (
    input  wire  logic              clk,
    input  wire  modsq_pkg::prod_t  product,
    output modsq_pkg::value_t       folded
);
    import modsq_pkg::*;

    // First fold is below 2^32 + 5 * 2^48, second below 2^32 + 5 * 2^19
    typedef logic [PROD_W-MOD_W+2:0] fold1_t;
    typedef logic [MOD_W:0]          fold2_t;

    fold1_t fold1;
    fold2_t fold2;

    // High part times 2^32 is congruent to high part times 5
    always_comb begin
        fold1 = fold1_t'(product[MOD_W-1:0])
              + fold1_t'(product[PROD_W-1:MOD_W]) * fold1_t'(FOLD_C);
    end

    always_comb begin
        fold2 = fold2_t'(fold1[MOD_W-1:0])
              + fold2_t'(fold1[PROD_W-MOD_W+2:MOD_W]) * fold2_t'(FOLD_C);
    end

    always_ff @(posedge clk) begin
        folded <= value_t'(fold2);
    end

    // Partial reduction must stay within one subtract of canonical
    assert property (@(posedge clk)
        !$isunknown(folded) |-> folded < (value_t'(MOD_P) << 1));

endmodule

`default_nettype wire

//--- square/square_loop_ctrl.sv
// Loop FSM sequencing load, square, fold, iteration count and finish
`default_nettype none

module square_loop_ctrl (
    input  wire  logic                        clk,
    input  wire  logic                        reset,
    input  wire  logic                        start,
    input  wire  logic [modsq_pkg::MOD_W-1:0] x_in,
    input  wire  logic [modsq_pkg::ITER_W-1:0] iter_count,
    input  wire  modsq_pkg::value_t           folded,
    output modsq_pkg::value_t                 loop_value,
    output modsq_pkg::value_t                 norm_in,
    output logic                              busy,
    output logic                              result_valid
);
    import modsq_pkg::*;

    loop_state_t       state;
    loop_state_t       state_next;
    logic [ITER_W-1:0] iter_left;
    logic              fold_ready;
    value_t            value_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = LOAD;
                end
            end
            // Zero iterations go straight to normalisation
            LOAD:      state_next = (iter_count == '0) ? NORMALIZE : SQUARE;
            SQUARE:    state_next = FOLD;
            FOLD:      state_next = (iter_left == ITER_W'(1)) ? NORMALIZE : SQUARE;
            NORMALIZE: state_next = DONE;
            DONE:      state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            iter_left  <= '0;
            fold_ready <= 1'b0;
        end else begin
            state      <= state_next;
            fold_ready <= (state == FOLD);
            if (state == LOAD) begin
                iter_left <= iter_count;
            end else if (state == FOLD) begin
                iter_left <= iter_left - 1'b1;
            end
        end
    end

    // Loop value holds x_in until the first fold result arrives
    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            value_q <= value_t'(x_in);
        end else if (fold_ready) begin
            value_q <= folded;
        end
    end

    // Right after FOLD the new value is taken straight from the fold register
    assign loop_value   = fold_ready ? folded : value_q;
    assign norm_in      = loop_value;
    assign busy         = (state != IDLE);
    assign result_valid = (state == DONE);

    assert property (@(posedge clk) disable iff (reset)
        state inside {IDLE, LOAD, SQUARE, FOLD, NORMALIZE, DONE});

    // The register block must hold off start until the loop is idle
    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

//--- rtl/final_normalize.sv
// Final normaliser that subtracts P once to give the canonical result
`default_nettype none

module final_normalize (
    input  wire  logic                        clk,
    input  wire  modsq_pkg::value_t           norm_in,
    output logic [modsq_pkg::MOD_W-1:0]       result
);
    import modsq_pkg::*;

    logic   at_least_p;
    value_t diff;

    assign at_least_p = (norm_in >= value_t'(MOD_P));
    assign diff       = norm_in - value_t'(MOD_P);

    // Input is below 2P, so one conditional subtract is enough
    always_ff @(posedge clk) begin
        if (at_least_p) begin
            result <= diff[MOD_W-1:0];
        end else begin
            result <= norm_in[MOD_W-1:0];
        end
    end

    assert property (@(posedge clk) !$isunknown(result) |-> result < MOD_P);

endmodule

`default_nettype wire

//--- rtl/modsq_top.sv
// Modular squaring engine top level joining the APB registers, squaring loop and normaliser
`default_nettype none

module modsq_top (
    input  wire  logic                          clk,
    input  wire  logic                          reset,
    input  wire  logic                          psel,
    input  wire  logic                          penable,
    input  wire  logic                          pwrite,
    input  wire  logic [modsq_pkg::ADDR_W-1:0]  paddr,
    input  wire  logic [31:0]                   pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr
);
    import modsq_pkg::*;

    logic              start;
    logic              busy;
    logic              result_valid;
    logic [MOD_W-1:0]  x_in;
    logic [MOD_W-1:0]  result;
    logic [ITER_W-1:0] iter_count;
    value_t            loop_value;
    value_t            folded;
    value_t            norm_in;
    prod_t             product;

    modsq_apb_regs modsq_apb_regs_i (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .start        (start),
        .x_in         (x_in),
        .iter_count   (iter_count)
    );

    square_loop_ctrl square_loop_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .x_in         (x_in),
        .iter_count   (iter_count),
        .folded       (folded),
        .loop_value   (loop_value),
        .norm_in      (norm_in),
        .busy         (busy),
        .result_valid (result_valid)
    );

    limb_square_array limb_square_array_i (
        .clk        (clk),
        .loop_value (loop_value),
        .product    (product)
    );

    fold_reduce fold_reduce_i (
        .clk     (clk),
        .product (product),
        .folded  (folded)
    );

    final_normalize final_normalize_i (
        .clk     (clk),
        .norm_in (norm_in),
        .result  (result)
    );

endmodule

`default_nettype wire

//--- tests/modsq_tests.svh
// Directed tests for the modular squaring engine, included in the testbench module
`ifndef MODSQ_TESTS_SVH
`define MODSQ_TESTS_SVH
`default_nettype none

    task automatic reset_state();
        int          errors_before;
        logic [31:0] data;
        logic        err;
        errors_before = error_count;
        apb_read(ADDR_STATUS, data, err);
        check_equal(data, 32'd0, "STATUS after reset");
        check_equal(32'(err), 32'd0, "pslverr on STATUS read");
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, 32'd0, "X_OUT after reset");
        apb_read(ADDR_ITER, data, err);
        check_equal(data, 32'd0, "ITER after reset");
        apb_read(ADDR_X_IN, data, err);
        check_equal(data, 32'd0, "X_IN after reset");
        report_test("reset_state", errors_before);
    endtask

    // P + 3 fits in 32 bits, so zero iterations must reduce it to 3
    task automatic zero_iterations();
        int          errors_before;
        logic [31:0] data;
        logic        err;
        errors_before = error_count;
        start_run(32'hFFFF_FFFE, 16'd0);
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, 32'd3, "X_OUT for x = P + 3 with no iterations");
        apb_read(ADDR_STATUS, data, err);
        check_equal(data, 32'd2, "STATUS done and idle");
        report_test("zero_iterations", errors_before);
    endtask

    task automatic known_values();
        int          errors_before;
        logic [31:0] data;
        logic        err;
        errors_before = error_count;
        // 2 squared five times is 2^32, which is 5 mod P
        start_run(32'd2, 16'd5);
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, 32'd5, "X_OUT for x = 2, five iterations");
        start_run(32'hFFFF_FFFA, 16'd1);
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, 32'd1, "X_OUT for x = P - 1, one iteration");
        report_test("known_values", errors_before);
    endtask

    task automatic random_operands();
        int          errors_before;
        logic [31:0] x;
        logic [15:0] iters;
        errors_before = error_count;
        for (int n = 0; n < 20; n++) begin
            x     = $urandom;
            iters = 16'(1 + ($urandom % 200));
            run_and_check(x, iters);
        end
        report_test("random_operands", errors_before);
    endtask

    task automatic bus_errors();
        int          errors_before;
        logic [31:0] data;
        logic        err;
        errors_before = error_count;
        apb_read(8'h14, data, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped read");
        apb_write(8'h20, 32'd1, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped write");
        apb_write(ADDR_X_OUT, 32'h1234_5678, err);
        check_equal(32'(err), 32'd1, "pslverr on X_OUT write");
        apb_write(ADDR_STATUS, 32'd3, err);
        check_equal(32'(err), 32'd1, "pslverr on STATUS write");

        start_run(32'h1234_5678, 16'd60);
        apb_read(ADDR_STATUS, data, err);
        check_equal(32'(data[0]), 32'd1, "busy while the loop runs");
        apb_write(ADDR_X_IN, 32'hDEAD_BEEF, err);
        check_equal(32'(err), 32'd1, "pslverr on X_IN write while busy");
        apb_write(ADDR_ITER, 32'd5, err);
        check_equal(32'(err), 32'd1, "pslverr on ITER write while busy");
        apb_write(ADDR_CTRL, 32'd1, err);
        check_equal(32'(err), 32'd1, "pslverr on CTRL write while busy");
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, expected_result(32'h1234_5678, 16'd60), "X_OUT after rejected writes");
        apb_read(ADDR_X_IN, data, err);
        check_equal(data, 32'h1234_5678, "X_IN kept after rejected write");
        apb_read(ADDR_ITER, data, err);
        check_equal(data, 32'd60, "ITER kept after rejected write");
        report_test("bus_errors", errors_before);
    endtask

    task automatic restart_after_done();
        int          errors_before;
        logic [31:0] data;
        logic        err;
        errors_before = error_count;
        run_and_check(32'd3, 16'd2);
        start_run(32'd7, 16'd3);
        apb_read(ADDR_STATUS, data, err);
        check_equal(32'(data[1]), 32'd0, "done cleared by a new start");
        check_equal(32'(data[0]), 32'd1, "busy after a new start");
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, expected_result(32'd7, 16'd3), "X_OUT replaced by the second run");
        report_test("restart_after_done", errors_before);
    endtask

`default_nettype wire
`endif

//--- tests/modsq_tb.sv
// Testbench for the modular squaring engine, driving directed tests over APB
`default_nettype none

module modsq_tb;
    import modsq_pkg::*;

    // Twenty random runs near 100 iterations plus APB traffic take about 5000 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [63:0] PRIME = (64'd1 << 32) - 64'd5;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int error_count;
    int tests_run;
    int tests_failed;
    int cycle_count;

    modsq_top modsq_top_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always begin
        #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s (got %h, expected %h)",
                     $time, what, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #10;
        err = pslverr;
        check_equal(32'(pready), 32'd1, "pready in write access phase");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #10;
        data = prdata;
        err  = pslverr;
        check_equal(32'(pready), 32'd1, "pready in read access phase");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // x mod P, then squared modulo P iters times
    function automatic logic [31:0] expected_result(input logic [31:0] x,
                                                    input logic [15:0] iters);
        logic [63:0] v;
        v = {32'd0, x} % PRIME;
        for (int i = 0; i < int'(iters); i++) begin
            v = (v * v) % PRIME;
        end
        return v[31:0];
    endfunction

    task automatic start_run(input logic [31:0] x, input logic [15:0] iters);
        logic err;
        apb_write(ADDR_ITER, {16'd0, iters}, err);
        check_equal(32'(err), 32'd0, "pslverr on ITER write");
        apb_write(ADDR_X_IN, x, err);
        check_equal(32'(err), 32'd0, "pslverr on X_IN write");
        apb_write(ADDR_CTRL, 32'd1, err);
        check_equal(32'(err), 32'd0, "pslverr on CTRL write");
    endtask

    // Poll STATUS until the done bit is set
    task automatic wait_done();
        logic [31:0] status;
        logic        err;
        status = '0;
        while (!status[1]) begin
            apb_read(ADDR_STATUS, status, err);
        end
    endtask

    task automatic run_and_check(input logic [31:0] x, input logic [15:0] iters);
        logic [31:0] data;
        logic        err;
        start_run(x, iters);
        wait_done();
        apb_read(ADDR_X_OUT, data, err);
        check_equal(data, expected_result(x, iters),
                    $sformatf("X_OUT for x=%h iter=%0d", x, iters));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count > errors_before) begin
            tests_failed++;
            $display("[fail] %s", name);
        end else begin
            $display("[ok]   %s", name);
        end
    endtask

`include "modsq_tests.svh"

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        void'($urandom(48));
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_state();
        zero_iterations();
        known_values();
        random_operands();
        bus_errors();
        restart_after_done();

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- modsq_top.f
+incdir+tests
common/modsq_pkg.sv
rtl/modsq_apb_regs.sv
square/limb_square_array.sv
square/fold_reduce.sv
square/square_loop_ctrl.sv
rtl/final_normalize.sv
rtl/modsq_top.sv
tests/modsq_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the modular squaring engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f modsq_top.f --top-module modsq_tb -o modsq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/modsq_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
